// File: bench/fetch_checker.sv
`default_nettype none
`timescale 1ns/10ps

`include "fetch_config.svh"

module fetch_checker (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req_valid,
    input  fetch_pkg::addr_t  req_addr,
    input  logic              credit_return,
    input  logic              rsp_valid,
    input  logic              redirect,
    input  fetch_pkg::addr_t  redirect_pc,
    input  logic              jalr,
    input  fetch_pkg::addr_t  jalr_pc,
    input  logic              mem_stall,
    input  logic              muldiv_start,
    input  logic              muldiv_done,
    input  logic              instr_valid,
    input  fetch_pkg::instr_t instr,
    input  fetch_pkg::addr_t  instr_pc,
    output int                value_errors,
    output int                flow_errors
);
    import fetch_pkg::*;

    localparam instr_t INSTR_KEY = 32'h5A5A_5A5A;

    addr_t exp_pc;       // next instr_pc decode should see
    addr_t next_pc;
    addr_t jalr_tgt;
    logic  jalr_wait;    // jalr seen with the load still to come
    logic  md_run;       // between muldiv_start and muldiv_done
    logic  held_done;    // a fetch came back while the pc is frozen
    logic  armed;
    logic  hold_now;
    int    credits;
    int    outstanding;
    int    n_value = 0;
    int    n_flow = 0;

    assign hold_now     = mem_stall || muldiv_start || md_run;
    assign value_errors = n_value;
    assign flow_errors  = n_flow;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            n_value++;
            $display("Fail %s: expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic report_flow(input string what);
        n_flow++;
        $display("Error: %s at %0t", what, $time);
    endtask

    always @(posedge clk or negedge rst_n) begin
        int out_next;
        if (!rst_n) begin
            exp_pc      <= `RESET_PC;
            jalr_wait   <= 1'b0;
            md_run      <= 1'b0;
            held_done   <= 1'b0;
            armed       <= 1'b0;
            credits     <= `FETCH_CREDITS;
            outstanding <= 0;
            if (req_valid === 1'b1 || instr_valid === 1'b1)
                report_flow("request or instruction output active during reset");
        end else begin
            armed <= 1'b1;
            if (!armed && (req_valid || instr_valid))
                report_flow("request or instruction output active right after reset");
            if (req_valid && credits == 0)
                report_flow("request issued with no credit left");
            if (req_valid)
                check_value("req_addr", exp_pc, req_addr);
            out_next = outstanding + int'(req_valid) - int'(rsp_valid);
            if (out_next > `FETCH_CREDITS)
                report_flow("more requests outstanding than credits");
            outstanding <= out_next;
            credits     <= credits + int'(credit_return) - int'(req_valid);

            next_pc = exp_pc;
            if (instr_valid) begin
                if (held_done)
                    report_flow("instruction delivered while the pc was held");
                check_value("instr_pc", exp_pc, instr_pc);
                check_value("instr", exp_pc ^ INSTR_KEY, instr);
                next_pc = exp_pc + 32'd4;
            end
            // stalls beat both and a waiting jalr beats a redirect
            if (jalr_wait && !hold_now && !jalr)
                next_pc = jalr_tgt;
            else if (redirect && !hold_now && !jalr && !jalr_wait)
                next_pc = redirect_pc;
            exp_pc    <= next_pc;
            jalr_wait <= jalr || (jalr_wait && hold_now);
            if (jalr)
                jalr_tgt <= jalr_pc;
            if (muldiv_start)
                md_run <= 1'b1;
            else if (muldiv_done)
                md_run <= 1'b0;
            held_done <= hold_now && (held_done || instr_valid);
        end
    end

endmodule

`default_nettype wire

// File: bench/fetch_tb.sv
`default_nettype none
`timescale 1ns/10ps

module fetch_tb;
    import fetch_pkg::*;

    typedef enum logic [2:0] {EV_NONE, EV_REDIRECT, EV_JALR, EV_STALL, EV_MULDIV} event_e;

    typedef struct packed {
        event_e     kind;
        addr_t      target;
        logic [3:0] cycles;   // wait after a pulse or length of a stall or muldiv
    } entry_t;

    localparam int     N_ENTRIES   = 14;
    localparam int     WAIT_LIMIT  = 40;  // cycles for one fetch to come back
    localparam int     ENTRY_WORST = WAIT_LIMIT + 24;
    localparam instr_t INSTR_KEY   = 32'h5A5A_5A5A;

    logic       clk = 1'b0;
    logic       rst_n, redirect, jalr, mem_stall, muldiv_start, muldiv_done;
    addr_t      redirect_pc, jalr_pc;
    logic       credit_return = 1'b0;
    logic       rsp_valid = 1'b0;
    instr_t     rsp_instr = '0;
    logic       req_valid, instr_valid;
    addr_t      req_addr, instr_pc;
    instr_t     instr;
    int         value_errors, flow_errors;
    int         wait_errors = 0;
    entry_t     stim [N_ENTRIES];
    logic [7:0] lfsr = 8'd74;
    int         cyc = 0;
    int         last_due = 0;
    int         last_credit = 0;
    addr_t      req_q [$];
    int         due_q [$];
    int         credit_q [$];

    fetch_top i_dut (.*);

    fetch_checker i_checker (.*);

    always #4 clk = ~clk;

    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = (value << 1) | lfsr[0];
        end
    endtask

    // in-order instruction memory answering in 1 to 4 cycles
    always @(posedge clk) begin
        int draw;
        cyc = cyc + 1;
        if (rst_n && req_valid) begin
            draw_bits(2, draw);
            last_due = (cyc + draw > last_due) ? cyc + draw : last_due + 1;
            req_q.push_back(req_addr);
            due_q.push_back(last_due);
        end
    end

    always @(negedge clk) begin
        int draw;
        rsp_valid     = 1'b0;
        credit_return = 1'b0;
        if (due_q.size() != 0 && due_q[0] <= cyc) begin
            rsp_valid = 1'b1;
            rsp_instr = req_q.pop_front() ^ INSTR_KEY;
            void'(due_q.pop_front());
            draw_bits(2, draw);  // credit held back up to 3 cycles
            last_credit = (cyc + draw > last_credit) ? cyc + draw : last_credit + 1;
            credit_q.push_back(last_credit);
        end
        if (credit_q.size() != 0 && credit_q[0] <= cyc) begin
            credit_return = 1'b1;
            void'(credit_q.pop_front());
        end
    end

    task automatic load_stimulus();
        stim[0]  = '{EV_NONE,     32'h0,         4'd3};
        stim[1]  = '{EV_NONE,     32'h0,         4'd1};
        stim[2]  = '{EV_REDIRECT, 32'h8000_0100, 4'd2};
        stim[3]  = '{EV_NONE,     32'h0,         4'd2};
        stim[4]  = '{EV_JALR,     32'h8000_0200, 4'd3};
        stim[5]  = '{EV_STALL,    32'h0,         4'd6};
        stim[6]  = '{EV_NONE,     32'h0,         4'd1};
        stim[7]  = '{EV_MULDIV,   32'h0,         4'd5};
        stim[8]  = '{EV_REDIRECT, 32'h8000_0040, 4'd1};
        stim[9]  = '{EV_MULDIV,   32'h0,         4'd1};
        stim[10] = '{EV_JALR,     32'h8000_0010, 4'd2};
        stim[11] = '{EV_STALL,    32'h0,         4'd3};
        stim[12] = '{EV_REDIRECT, 32'h8000_1000, 4'd0};
        stim[13] = '{EV_MULDIV,   32'h0,         4'd8};
    endtask

    task automatic wait_for_fetch();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (instr_valid !== 1'b1 && n < WAIT_LIMIT);
        if (instr_valid !== 1'b1) begin
            wait_errors++;
            $display("Error: no instruction came back within %0d cycles", WAIT_LIMIT);
        end
        repeat (2) @(negedge clk);  // muldiv tracker back in idle
    endtask

    task automatic apply_entry(input entry_t e);
        case (e.kind)
            EV_REDIRECT: begin
                redirect    = 1'b1;
                redirect_pc = e.target;
                @(negedge clk);
                redirect = 1'b0;
                repeat (e.cycles) @(negedge clk);
            end
            EV_JALR: begin
                jalr    = 1'b1;
                jalr_pc = e.target;
                @(negedge clk);
                jalr = 1'b0;
                repeat (e.cycles) @(negedge clk);
            end
            EV_STALL: begin
                mem_stall = 1'b1;
                repeat (e.cycles) @(negedge clk);
                mem_stall = 1'b0;
            end
            EV_MULDIV: begin
                muldiv_start = 1'b1;
                @(negedge clk);
                muldiv_start = 1'b0;
                repeat (e.cycles - 1) @(negedge clk);
                muldiv_done = 1'b1;
                @(negedge clk);
                muldiv_done = 1'b0;
            end
            default: repeat (e.cycles) @(negedge clk);
        endcase
    endtask

    initial begin
        rst_n        = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        jalr         = 1'b0;
        jalr_pc      = '0;
        mem_stall    = 1'b0;
        muldiv_start = 1'b0;
        muldiv_done  = 1'b0;
        load_stimulus();
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        foreach (stim[i]) begin
            wait_for_fetch();
            apply_entry(stim[i]);
        end
        wait_for_fetch();  // fetching must carry on after the last event
        repeat (4) @(negedge clk);
        $display("errors: value %0d, flow %0d, timeout %0d",
                 value_errors, flow_errors, wait_errors);
        if (value_errors + flow_errors + wait_errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // backstop in case a wait loop itself gets stuck
    initial begin
        repeat (4 + N_ENTRIES * ENTRY_WORST + WAIT_LIMIT) @(posedge clk);
        $display("Error: watchdog expired before the table finished, value %0d, flow %0d",
                 value_errors, flow_errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// address and instruction word width
`define XLEN 32

// first fetch address out of reset
`define RESET_PC 32'h8000_0000

// request slots the instruction memory grants after reset
`define FETCH_CREDITS 2

// redirect generation tag wide enough for the credits in flight
`define EPOCH_W 2

`endif

// File: rtl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    `include "fetch_config.svh"

    typedef logic [`XLEN-1:0]    addr_t;
    typedef logic [`XLEN-1:0]    instr_t;
    typedef logic [`EPOCH_W-1:0] epoch_t;

    // counts from zero up to the full credit grant
    typedef logic [$clog2(`FETCH_CREDITS + 1)-1:0] credit_cnt_t;

    typedef enum logic [1:0] {
        STEP_HOLD     = 2'd0,
        STEP_SEQ      = 2'd1,  // pc + 4
        STEP_REDIRECT = 2'd2,
        STEP_JALR     = 2'd3
    } pc_step_e;

    typedef enum logic [1:0] {
        MD_IDLE        = 2'd0,
        MD_ARITH       = 2'd1,  // unit running
        MD_AWAIT_FETCH = 2'd2,  // result back with the fetch still out
        MD_TAIL        = 2'd3
    } md_state_e;

endpackage

`default_nettype wire

// File: rtl/fetch_requester.sv
`default_nettype none
`timescale 1ns/10ps

`include "fetch_config.svh"

module fetch_requester (
    input  logic              clk,
    input  logic              rst_n,
    input  fetch_pkg::addr_t  pc,
    input  logic              changed,
    output logic              req_valid,
    output fetch_pkg::addr_t  req_addr,
    input  logic              credit_return,
    input  logic              rsp_valid,
    input  fetch_pkg::instr_t rsp_instr,
    output logic              instr_valid,
    output fetch_pkg::instr_t instr,
    output fetch_pkg::addr_t  instr_pc,
    output logic              fetch_done
);
    import fetch_pkg::*;

    localparam int DEPTH = `FETCH_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic             armed;         // low for the first cycle out of reset
    credit_cnt_t      credits;
    credit_cnt_t      q_cnt;
    epoch_t           epoch;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    epoch_t           q_epoch [DEPTH];
    addr_t            q_addr  [DEPTH];
    logic             req_made;
    addr_t            req_pc;
    epoch_t           req_epoch;
    logic             need_req;
    logic             accept;
    logic             deliver_q;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // one request per pc and epoch
    assign need_req  = !req_made || (pc != req_pc) || (epoch != req_epoch);
    assign req_valid = armed && (credits != '0) && need_req && !changed;
    assign req_addr  = pc;

    // a response landing during a load belongs to the old path too
    assign accept = rsp_valid && (q_epoch[rd_ptr] == epoch) && !changed;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed     <= 1'b0;
            credits   <= credit_cnt_t'(`FETCH_CREDITS);
            q_cnt     <= '0;
            epoch     <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            req_made  <= 1'b0;
            deliver_q <= 1'b0;
        end else begin
            armed     <= 1'b1;
            deliver_q <= accept;
            if (changed)
                epoch <= epoch + epoch_t'(1);
            case ({req_valid, credit_return})
                2'b10:   credits <= credits - credit_cnt_t'(1);
                2'b01:   credits <= credits + credit_cnt_t'(1);
                default: credits <= credits;
            endcase
            case ({req_valid, rsp_valid})
                2'b10:   q_cnt <= q_cnt + credit_cnt_t'(1);
                2'b01:   q_cnt <= q_cnt - credit_cnt_t'(1);
                default: q_cnt <= q_cnt;
            endcase
            if (req_valid) begin
                wr_ptr   <= ptr_inc(wr_ptr);
                req_made <= 1'b1;
            end
            if (rsp_valid)
                rd_ptr <= ptr_inc(rd_ptr);  // stale ones are popped as well
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_epoch[wr_ptr] <= epoch;
            q_addr[wr_ptr]  <= pc;
            req_pc          <= pc;
            req_epoch       <= epoch;
        end
        if (accept) begin
            instr    <= rsp_instr;
            instr_pc <= q_addr[rd_ptr];
        end
    end

    assign instr_valid = deliver_q;
    assign fetch_done  = deliver_q;

    // memory returned more credits than it was ever given
    a_credit_max: assert property (
        @(posedge clk) disable iff (!rst_n) credits <= credit_cnt_t'(`FETCH_CREDITS));

    // every response must match an earlier request
    a_rsp_has_req: assert property (
        @(posedge clk) disable iff (!rst_n) rsp_valid |-> q_cnt != '0);

endmodule

`default_nettype wire

// File: rtl/fetch_top.sv
`default_nettype none
`timescale 1ns/10ps

module fetch_top (
    input  logic              clk,
    input  logic              rst_n,
    // instruction memory
    output logic              req_valid,
    output fetch_pkg::addr_t  req_addr,
    input  logic              credit_return,
    input  logic              rsp_valid,
    input  fetch_pkg::instr_t rsp_instr,
    // decode side
    input  logic              redirect,
    input  fetch_pkg::addr_t  redirect_pc,
    input  logic              jalr,
    input  fetch_pkg::addr_t  jalr_pc,
    input  logic              mem_stall,
    input  logic              muldiv_start,
    input  logic              muldiv_done,
    output logic              instr_valid,
    output fetch_pkg::instr_t instr,
    output fetch_pkg::addr_t  instr_pc
);

    logic fetch_done;

    pc_step_if step_if ();

    pc_control i_pc_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .jalr         (jalr),
        .jalr_pc      (jalr_pc),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .mem_stall    (mem_stall),
        .muldiv_start (muldiv_start),
        .muldiv_done  (muldiv_done),
        .fetch_done   (fetch_done),
        .step_port    (step_if.ctrl)
    );

    pc_register i_pc_register (
        .clk       (clk),
        .rst_n     (rst_n),
        .step_port (step_if.datapath)
    );

    fetch_requester i_fetch_requester (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc            (step_if.pc),
        .changed       (step_if.changed),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp_instr     (rsp_instr),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .fetch_done    (fetch_done)
    );

endmodule

`default_nettype wire

// File: rtl/pc_control.sv
`default_nettype none
`timescale 1ns/10ps

module pc_control (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             jalr,
    input  fetch_pkg::addr_t jalr_pc,
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             mem_stall,
    input  logic             muldiv_start,
    input  logic             muldiv_done,
    input  logic             fetch_done,
    pc_step_if.ctrl          step_port
);
    import fetch_pkg::*;

    md_state_e md_state;
    md_state_e md_next;
    logic      md_advance;
    logic      md_busy;
    logic      fetch_owed;     // completed fetch not yet turned into a step
    logic      fetch_seen;
    logic      jalr_pending;
    addr_t     jalr_target;
    pc_step_e  step_d;

    assign fetch_seen = fetch_done || fetch_owed;

    always_comb begin
        md_next    = md_state;
        md_advance = 1'b0;
        case (md_state)
            MD_IDLE: begin
                if (muldiv_start)
                    md_next = MD_ARITH;
            end
            MD_ARITH: begin
                if (muldiv_done) begin
                    if (fetch_seen) begin
                        md_next    = MD_TAIL;
                        md_advance = 1'b1;
                    end else begin
                        md_next = MD_AWAIT_FETCH;
                    end
                end
            end
            MD_AWAIT_FETCH: begin
                if (fetch_seen) begin
                    md_next    = MD_TAIL;
                    md_advance = 1'b1;
                end
            end
            default: md_next = MD_IDLE;  // tail lasts one cycle
        endcase
    end

    // pc frozen from start until the result and a fetch have both arrived
    assign md_busy = (md_state == MD_IDLE && muldiv_start) ||
                     ((md_state == MD_ARITH || md_state == MD_AWAIT_FETCH) && !md_advance);

    always_comb begin
        if (md_busy)
            step_d = STEP_HOLD;
        else if (mem_stall)
            step_d = STEP_HOLD;
        else if (jalr)
            step_d = STEP_HOLD;      // target lands next cycle
        else if (jalr_pending)
            step_d = STEP_JALR;
        else if (redirect)
            step_d = STEP_REDIRECT;
        else if (fetch_seen)
            step_d = STEP_SEQ;
        else
            step_d = STEP_HOLD;
    end

    assign step_port.step   = step_d;
    assign step_port.target = (step_d == STEP_JALR) ? jalr_target : redirect_pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            md_state     <= MD_IDLE;
            fetch_owed   <= 1'b0;
            jalr_pending <= 1'b0;
        end else begin
            md_state     <= md_next;
            fetch_owed   <= fetch_seen && (step_d == STEP_HOLD);
            jalr_pending <= jalr || (jalr_pending && step_d != STEP_JALR);
        end
    end

    always_ff @(posedge clk) begin
        if (jalr)
            jalr_target <= jalr_pc;
    end

    // decode never raises both in one cycle
    a_redirect_jalr_excl: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0({redirect, jalr}));

    // a result without a started operation means decode lost track
    a_done_needs_start: assert property (
        @(posedge clk) disable iff (!rst_n) muldiv_done |-> md_state != MD_IDLE);

endmodule

`default_nettype wire

// File: rtl/pc_register.sv
`default_nettype none
`timescale 1ns/10ps

`include "fetch_config.svh"

module pc_register (
    input  logic         clk,
    input  logic         rst_n,
    pc_step_if.datapath  step_port
);
    import fetch_pkg::*;

    addr_t pc_q;
    addr_t pc_d;
    logic  load;

    assign load = (step_port.step == STEP_REDIRECT) || (step_port.step == STEP_JALR);

    always_comb begin
        case (step_port.step)
            STEP_SEQ:                 pc_d = pc_q + addr_t'(4);
            STEP_REDIRECT, STEP_JALR: pc_d = step_port.target;
            default:                  pc_d = pc_q;  // hold
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc_q <= `RESET_PC;
        else
            pc_q <= pc_d;
    end

    assign step_port.pc      = pc_q;
    assign step_port.changed = load;  // epoch moves together with the pc

    // misaligned decode targets would show up here
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: rtl/pc_step_if.sv
`default_nettype none
`timescale 1ns/10ps

interface pc_step_if;
    import fetch_pkg::*;

    pc_step_e step;     // what the pc does at the next edge
    addr_t    target;   // load value for redirect and jalr
    addr_t    pc;
    logic     changed;  // target load this cycle starting a new epoch

    // decision side
    modport ctrl (
        output step,
        output target
    );

    // pc holder
    modport datapath (
        input  step,
        input  target,
        output pc,
        output changed
    );

endinterface

`default_nettype wire

// File: verilog.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/pc_step_if.sv
rtl/pc_control.sv
rtl/pc_register.sv
rtl/fetch_requester.sv
rtl/fetch_top.sv
bench/fetch_checker.sv
bench/fetch_tb.sv
